// File: files.f
logic/masked_pkg.sv
logic/mask_rng_pkg.sv
logic/masked_full_adder.sv
logic/masked_boolean_addsub.sv
logic/mask_rng_feeder.sv
logic/share_refresh_collector.sv
logic/masked_arith_top.sv
sim/masked_arith_props.sv
sim/masked_arith_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the masked arithmetic testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module masked_arith_tb \
    -f files.f

./obj_dir/Vmasked_arith_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    exit 1
fi

// File: sim/masked_arith_tb.sv
/*
 * Testbench for the masked arithmetic unit
 * Splits random operands into two shares, drives the lanes and
 * unmasks the result shares in a monitor that knows when each
 * result is due. Directed tests cover add, sub, latency,
 * streaming, zeroize and remasking
 */
`timescale 1ns/100ps
`default_nettype none

module masked_arith_tb
    import masked_pkg::*;
    import mask_rng_pkg::*;
;

    localparam int WIDTH     = DEF_WIDTH;
    localparam int NUM_LANES = DEF_LANES;
    localparam int LAT       = WIDTH + 4;   // in_valid cycle to out_valid cycle
    localparam int TIMEOUT   = 50;

    logic                       clk;
    logic                       rst_n;
    logic                       zeroize;
    logic                       seed_load;
    logic [LFSR_WIDTH-1:0]      seed;
    logic [NUM_LANES-1:0]       in_valid;
    logic [NUM_LANES-1:0]       sub;
    logic [NUM_LANES*WIDTH-1:0] x_share0, x_share1;
    logic [NUM_LANES*WIDTH-1:0] y_share0, y_share1;
    logic [NUM_LANES-1:0]       out_valid;
    logic [NUM_LANES*WIDTH-1:0] s_share0, s_share1;

    // Expected results per lane, value and negedge count when due
    logic [WIDTH-1:0] exp_val_q[NUM_LANES][$];
    int               exp_cyc_q[NUM_LANES][$];
    logic [WIDTH-1:0] last_s0[NUM_LANES];     // Share0 of the latest result

    int ncyc;                                 // Negedge counter
    int errors;
    int checks;
    int tests;
    int failed_tests;
    int err_mark;

    always #5 clk = ~clk;

    masked_arith_top #(.WIDTH(WIDTH), .NUM_LANES(NUM_LANES)) u_masked_arith_top (
        .clk, .rst_n, .zeroize, .seed_load, .seed,
        .in_valid, .sub, .x_share0, .x_share1, .y_share0, .y_share1,
        .out_valid, .s_share0, .s_share1
    );

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_word(input string name, input logic [WIDTH-1:0] got,
                              input logic [WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    // ============================================================
    // Output monitor, sampled at negedge when outputs are settled
    // ============================================================
    always @(negedge clk) begin : monitor
        logic             due;
        logic [WIDTH-1:0] s0;
        logic [WIDTH-1:0] s1;
        ncyc++;
        if (rst_n) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                s0 = s_share0[l*WIDTH +: WIDTH];
                s1 = s_share1[l*WIDTH +: WIDTH];
                if (exp_cyc_q[l].size() > 0 && exp_cyc_q[l][0] < ncyc) begin
                    errors++;                  // Slot passed with no result
                    $display("Lane %0d result missing at t=%0t", l, $time);
                    void'(exp_val_q[l].pop_front());
                    void'(exp_cyc_q[l].pop_front());
                end
                due = (exp_cyc_q[l].size() > 0) && (exp_cyc_q[l][0] == ncyc);
                check_bit($sformatf("out_valid[%0d]", l), out_valid[l], due);
                if (due) begin
                    check_word($sformatf("s[%0d]", l), s0 ^ s1, exp_val_q[l].pop_front());
                    void'(exp_cyc_q[l].pop_front());
                    last_s0[l] = s0;
                end else if (!out_valid[l]) begin
                    check_word($sformatf("s_share0[%0d]", l), s0, '0);  // Idle shares
                    check_word($sformatf("s_share1[%0d]", l), s1, '0);
                end
            end
        end
    end

    // ============================================================
    // Drive helpers
    // ============================================================
    task automatic step();
        @(posedge clk);
        in_valid  <= '0;
        sub       <= '0;
        seed_load <= 1'b0;
    endtask

    // Drives one lane with the given operand masks and queues x+y or x-y
    task automatic drive_shares(input int lane, input logic [WIDTH-1:0] x,
                                input logic [WIDTH-1:0] y, input logic do_sub,
                                input logic [WIDTH-1:0] xm, input logic [WIDTH-1:0] ym);
        in_valid[lane]                   <= 1'b1;
        sub[lane]                        <= do_sub;
        x_share0[lane*WIDTH +: WIDTH]    <= xm;
        x_share1[lane*WIDTH +: WIDTH]    <= x ^ xm;
        y_share0[lane*WIDTH +: WIDTH]    <= ym;
        y_share1[lane*WIDTH +: WIDTH]    <= y ^ ym;
        exp_val_q[lane].push_back(do_sub ? x - y : x + y);
        exp_cyc_q[lane].push_back(ncyc + 1 + LAT);   // in_valid seen at next negedge
    endtask

    // Fresh random masks on both operands
    task automatic issue_op(input int lane, input logic [WIDTH-1:0] x,
                            input logic [WIDTH-1:0] y, input logic do_sub);
        logic [WIDTH-1:0] xm;
        logic [WIDTH-1:0] ym;
        xm = WIDTH'($urandom());
        ym = WIDTH'($urandom());
        drive_shares(lane, x, y, do_sub, xm, ym);
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            n += exp_val_q[l].size();
        end
        return n;
    endfunction

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (pending() > 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pending() > 0) begin
            $display("Timeout in %s, out_valid never came for %0d results", what, pending());
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic start_test();
        err_mark = errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != err_mark) begin
            failed_tests++;
        end
        $display("%-24s %s (%0d errors)", name, (errors == err_mark) ? "ok" : "FAILED",
                 errors - err_mark);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic add_all_lanes();
        start_test();
        step();
        for (int l = 0; l < NUM_LANES; l++) begin
            issue_op(l, WIDTH'($urandom()), WIDTH'($urandom()), 1'b0);
        end
        step();
        wait_drain("add");
        finish_test("add on every lane");
    endtask

    task automatic sub_wrap();
        start_test();
        step();
        issue_op(0, 8'd3, 8'd5, 1'b1);         // Wraps to 0xFE
        issue_op(1, 8'd0, 8'd1, 1'b1);
        issue_op(2, 8'h80, 8'h7F, 1'b1);
        issue_op(3, WIDTH'($urandom()), WIDTH'($urandom()), 1'b1);
        step();
        wait_drain("sub");
        finish_test("sub with wraparound");
    endtask

    // Monitor checks the exact slot and the idle lanes
    task automatic single_lane_latency();
        start_test();
        step();
        issue_op(1, WIDTH'($urandom()), WIDTH'($urandom()), 1'b0);
        step();
        wait_drain("latency");
        finish_test("fixed latency");
    endtask

    task automatic streaming();
        start_test();
        for (int c = 0; c < 20; c++) begin
            step();
            for (int l = 0; l < NUM_LANES; l++) begin
                issue_op(l, WIDTH'($urandom()), WIDTH'($urandom()), 1'($urandom()));
            end
        end
        step();
        wait_drain("streaming");
        finish_test("streaming");
    endtask

    task automatic zeroize_flush();
        start_test();
        step();
        for (int l = 0; l < NUM_LANES; l++) begin
            issue_op(l, WIDTH'($urandom()), WIDTH'($urandom()), 1'b0);
        end
        repeat (4) step();
        zeroize <= 1'b1;
        for (int l = 0; l < NUM_LANES; l++) begin
            exp_val_q[l].delete();             // In-flight items are dropped
            exp_cyc_q[l].delete();
        end
        step();
        zeroize <= 1'b0;
        repeat (LAT + 4) step();               // Any stray out_valid is flagged
        issue_op(2, WIDTH'($urandom()), WIDTH'($urandom()), 1'b1);
        step();
        wait_drain("after zeroize");
        finish_test("zeroize");
    endtask

    // Operand masks fixed across repeats so only the unit's randomness moves share0
    task automatic remask_repeat();
        logic [WIDTH-1:0] seen[8];
        logic [WIDTH-1:0] xm;
        logic [WIDTH-1:0] ym;
        logic             differ;
        start_test();
        differ = 1'b0;
        xm     = WIDTH'($urandom());
        ym     = WIDTH'($urandom());
        for (int r = 0; r < 8; r++) begin
            step();
            seed_load <= 1'b1;
            seed      <= $urandom();
            step();
            drive_shares(0, 8'h5A, 8'h3C, 1'b0, xm, ym);
            step();
            wait_drain("remask");
            seen[r] = last_s0[0];
            if (seen[r] !== seen[0]) begin
                differ = 1'b1;
            end
        end
        if (!differ) begin
            errors++;
            $display("Remasking: share0 was the same in all eight repeats");
        end
        finish_test("remasking");
    endtask

    initial begin
        void'($urandom(11));
        clk       = 1'b0;
        rst_n     = 1'b0;
        zeroize   = 1'b0;
        seed_load = 1'b0;
        seed      = '0;
        in_valid  = '0;
        sub       = '0;
        x_share0  = '0;
        x_share1  = '0;
        y_share0  = '0;
        y_share1  = '0;
        ncyc      = 0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        failed_tests = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        add_all_lanes();
        sub_wrap();
        single_lane_latency();
        streaming();
        zeroize_flush();
        remask_repeat();
        repeat (2) step();
        $display("tests=%0d failed=%0d checks=%0d errors=%0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : masked_arith_tb

`default_nettype wire

// File: sim/masked_arith_props.sv
/*
 * Protocol properties of the masked arithmetic top level
 * Fixed result latency, quiet outputs after reset and zero
 * shares on every idle lane
 */
`timescale 1ns/100ps
`default_nettype none

module masked_arith_props
    import masked_pkg::*;
#(
    parameter int WIDTH     = DEF_WIDTH,
    parameter int NUM_LANES = DEF_LANES
) (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       zeroize,
    input logic [NUM_LANES-1:0]       in_valid,
    input logic [NUM_LANES-1:0]       out_valid,
    input logic [NUM_LANES*WIDTH-1:0] s_share0,
    input logic [NUM_LANES*WIDTH-1:0] s_share1
);

    // Feeder stage, adder, collector
    localparam int LAT = 1 + WIDTH + ADDSUB_EXTRA_LAT + COLLECT_LAT;

    logic [7:0] quiet_q;                      // Cycles since reset or zeroize

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            quiet_q <= '0;
        end else if (quiet_q != 8'hFF) begin
            quiet_q <= quiet_q + 8'd1;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> (out_valid == '0))
        else $error("out_valid high right after reset");

    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane_props
        a_latency: assert property (@(posedge clk) disable iff (!rst_n)
            ($past(in_valid[l], LAT) && int'(quiet_q) >= LAT - 1) |-> out_valid[l])
            else $error("lane %0d out_valid missing after in_valid", l);

        a_zero_idle: assert property (@(posedge clk) disable iff (!rst_n)
            !out_valid[l] |-> (s_share0[l*WIDTH +: WIDTH] == '0
                               && s_share1[l*WIDTH +: WIDTH] == '0))
            else $error("lane %0d shares nonzero while idle", l);
    end

endmodule : masked_arith_props

bind masked_arith_top masked_arith_props #(.WIDTH(WIDTH), .NUM_LANES(NUM_LANES))
    u_masked_arith_props (
    .clk(clk), .rst_n(rst_n), .zeroize(zeroize), .in_valid(in_valid),
    .out_valid(out_valid), .s_share0(s_share0), .s_share1(s_share1)
);

`default_nettype wire

// File: logic/masked_arith_top.sv
/*
 * Masked arithmetic unit, top level
 * Randomness feeder, one masked adder/subtractor per lane and
 * the remasking collector. Lane words are packed lane 0 low
 */
`timescale 1ns/100ps
`default_nettype none

module masked_arith_top
    import masked_pkg::*;
    import mask_rng_pkg::*;
#(
    parameter int WIDTH     = DEF_WIDTH,
    parameter int NUM_LANES = DEF_LANES
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       zeroize,
    input  logic                       seed_load,
    input  logic [LFSR_WIDTH-1:0]      seed,
    input  logic [NUM_LANES-1:0]       in_valid,
    input  logic [NUM_LANES-1:0]       sub,
    input  logic [NUM_LANES*WIDTH-1:0] x_share0,
    input  logic [NUM_LANES*WIDTH-1:0] x_share1,
    input  logic [NUM_LANES*WIDTH-1:0] y_share0,
    input  logic [NUM_LANES*WIDTH-1:0] y_share1,
    output logic [NUM_LANES-1:0]       out_valid,
    output logic [NUM_LANES*WIDTH-1:0] s_share0,
    output logic [NUM_LANES*WIDTH-1:0] s_share1
);

    logic [NUM_LANES-1:0]       lane_valid;
    logic [NUM_LANES-1:0]       lane_sub;
    logic [NUM_LANES*WIDTH-1:0] lane_x0, lane_x1;
    logic [NUM_LANES*WIDTH-1:0] lane_y0, lane_y1;
    logic [NUM_LANES*WIDTH-1:0] lane_rnd, refresh_rnd;
    logic [NUM_LANES*WIDTH-1:0] lane_s0, lane_s1;  // Adder results, pre remask

    mask_rng_feeder #(.WIDTH(WIDTH), .NUM_LANES(NUM_LANES)) u_mask_rng_feeder (
        .clk, .rst_n, .seed_load, .seed,
        .in_valid, .sub, .x_share0, .x_share1, .y_share0, .y_share1,
        .lane_valid, .lane_sub, .lane_x0, .lane_x1, .lane_y0, .lane_y1,
        .lane_rnd, .refresh_rnd
    );

    // ============================================================
    // Lanes
    // ============================================================
    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
        logic [WIDTH-1:0][N_SHARES-1:0] x_bits;   // Bit b = {share1, share0}
        logic [WIDTH-1:0][N_SHARES-1:0] y_bits;
        logic [WIDTH-1:0][N_SHARES-1:0] s_bits;

        for (genvar b = 0; b < WIDTH; b++) begin : gen_split
            assign x_bits[b] = {lane_x1[l*WIDTH+b], lane_x0[l*WIDTH+b]};
            assign y_bits[b] = {lane_y1[l*WIDTH+b], lane_y0[l*WIDTH+b]};
            assign lane_s0[l*WIDTH+b] = s_bits[b][0];
            assign lane_s1[l*WIDTH+b] = s_bits[b][1];
        end

        masked_boolean_addsub #(.WIDTH(WIDTH)) u_masked_boolean_addsub (
            .clk     (clk),
            .rst_n   (rst_n),
            .zeroize (zeroize),
            .sub_i   (lane_sub[l]),
            .x       (x_bits),
            .y       (y_bits),
            .rnd     (lane_rnd[l*WIDTH +: WIDTH]),
            .s       (s_bits)
        );
    end

    share_refresh_collector #(.WIDTH(WIDTH), .NUM_LANES(NUM_LANES))
        u_share_refresh_collector (
        .clk, .rst_n, .zeroize,
        .lane_valid, .lane_s0, .lane_s1, .refresh_rnd,
        .out_valid, .s_share0, .s_share1
    );

endmodule : masked_arith_top

`default_nettype wire

// File: logic/share_refresh_collector.sv
/*
 * Result collector with share refresh
 * Delays each lane's valid and remask word by the adder latency,
 * then XORs the same fresh word into both result shares.
 * Shares of a lane without valid are forced to zero
 */
`timescale 1ns/100ps
`default_nettype none

module share_refresh_collector
    import masked_pkg::*;
#(
    parameter int WIDTH     = DEF_WIDTH,
    parameter int NUM_LANES = DEF_LANES
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       zeroize,
    input  logic [NUM_LANES-1:0]       lane_valid,
    input  logic [NUM_LANES*WIDTH-1:0] lane_s0,
    input  logic [NUM_LANES*WIDTH-1:0] lane_s1,
    input  logic [NUM_LANES*WIDTH-1:0] refresh_rnd,
    output logic [NUM_LANES-1:0]       out_valid,
    output logic [NUM_LANES*WIDTH-1:0] s_share0,
    output logic [NUM_LANES*WIDTH-1:0] s_share1
);

    localparam int ALIGN_LAT = WIDTH + ADDSUB_EXTRA_LAT;   // Lane input to lane s
    localparam int VPIPE_LEN = ALIGN_LAT + COLLECT_LAT;

    logic [NUM_LANES-1:0][VPIPE_LEN-1:0]       vpipe_q;    // Valid shift per lane
    logic [ALIGN_LAT-1:0][NUM_LANES*WIDTH-1:0] rnd_dly_q;  // Remask word delay

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vpipe_q <= '0;
        end else if (zeroize) begin
            vpipe_q <= '0;                 // Drop everything in flight
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                vpipe_q[l] <= {vpipe_q[l][VPIPE_LEN-2:0], lane_valid[l]};
            end
        end
    end

    always_ff @(posedge clk) begin
        rnd_dly_q[0] <= refresh_rnd;
        for (int k = 1; k < ALIGN_LAT; k++) begin
            rnd_dly_q[k] <= rnd_dly_q[k-1];
        end
    end

    // ============================================================
    // Remask and output register
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_share0 <= '0;
            s_share1 <= '0;
        end else if (zeroize) begin
            s_share0 <= '0;
            s_share1 <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (vpipe_q[l][ALIGN_LAT-1]) begin   // Aligned with lane s
                    s_share0[l*WIDTH +: WIDTH] <= lane_s0[l*WIDTH +: WIDTH]
                                                ^ rnd_dly_q[ALIGN_LAT-1][l*WIDTH +: WIDTH];
                    s_share1[l*WIDTH +: WIDTH] <= lane_s1[l*WIDTH +: WIDTH]
                                                ^ rnd_dly_q[ALIGN_LAT-1][l*WIDTH +: WIDTH];
                end else begin
                    s_share0[l*WIDTH +: WIDTH] <= '0;
                    s_share1[l*WIDTH +: WIDTH] <= '0;
                end
            end
        end
    end

    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_valid_out
        assign out_valid[l] = vpipe_q[l][VPIPE_LEN-1];
    end

endmodule : share_refresh_collector

`default_nettype wire

// File: logic/mask_rng_feeder.sv
/*
 * Mask randomness feeder
 * One Galois register per lane, stepped 2*WIDTH times per cycle
 * so every cycle gets fresh adder and remask bits. Also registers
 * the lane inputs so operands and randomness leave together
 */
`timescale 1ns/100ps
`default_nettype none

module mask_rng_feeder
    import masked_pkg::*;
    import mask_rng_pkg::*;
#(
    parameter int WIDTH     = DEF_WIDTH,
    parameter int NUM_LANES = DEF_LANES
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       seed_load,
    input  logic [LFSR_WIDTH-1:0]      seed,
    input  logic [NUM_LANES-1:0]       in_valid,
    input  logic [NUM_LANES-1:0]       sub,
    input  logic [NUM_LANES*WIDTH-1:0] x_share0,
    input  logic [NUM_LANES*WIDTH-1:0] x_share1,
    input  logic [NUM_LANES*WIDTH-1:0] y_share0,
    input  logic [NUM_LANES*WIDTH-1:0] y_share1,
    output logic [NUM_LANES-1:0]       lane_valid,
    output logic [NUM_LANES-1:0]       lane_sub,
    output logic [NUM_LANES*WIDTH-1:0] lane_x0,
    output logic [NUM_LANES*WIDTH-1:0] lane_x1,
    output logic [NUM_LANES*WIDTH-1:0] lane_y0,
    output logic [NUM_LANES*WIDTH-1:0] lane_y1,
    output logic [NUM_LANES*WIDTH-1:0] lane_rnd,
    output logic [NUM_LANES*WIDTH-1:0] refresh_rnd
);

    localparam int RND_BITS = N_SHARES * WIDTH;   // Adder word + remask word

    logic [NUM_LANES-1:0][LFSR_WIDTH-1:0] lfsr_q;
    logic [NUM_LANES-1:0][LFSR_WIDTH-1:0] lfsr_d;
    logic [NUM_LANES-1:0][RND_BITS-1:0]   rnd_d;
    logic [NUM_LANES-1:0][RND_BITS-1:0]   rnd_q;
    logic [LFSR_WIDTH-1:0]                seed_base;

    function automatic logic [LFSR_WIDTH-1:0] lfsr_step(input logic [LFSR_WIDTH-1:0] st);
        logic [LFSR_WIDTH-1:0] nxt;
        nxt = st >> 1;
        if (st[0]) begin
            nxt = nxt ^ LFSR_POLY;         // Feedback taps
        end
        return nxt;
    endfunction

    // Salted lane seed, falls back if the salt cancels the seed
    function automatic logic [LFSR_WIDTH-1:0] lane_seed(input logic [LFSR_WIDTH-1:0] base,
                                                        input int lane);
        logic [LFSR_WIDTH-1:0] st;
        st = base ^ (LANE_SEED_SALT * LFSR_WIDTH'(lane));
        return (st == '0) ? DEF_SEED : st;
    endfunction

    assign seed_base = (seed == '0) ? DEF_SEED : seed;   // All-zero would lock up

    always_comb begin
        logic [LFSR_WIDTH-1:0] st;
        for (int l = 0; l < NUM_LANES; l++) begin
            st = lfsr_q[l];
            for (int k = 0; k < RND_BITS; k++) begin
                rnd_d[l][k] = st[0];       // Take the bit shifted out
                st          = lfsr_step(st);
            end
            lfsr_d[l] = st;
        end
    end

    // Generators ignore zeroize and keep running
    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (!rst_n) begin
                lfsr_q[l] <= lane_seed(DEF_SEED, l);
            end else if (seed_load) begin
                lfsr_q[l] <= lane_seed(seed_base, l);
            end else begin
                lfsr_q[l] <= lfsr_d[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_valid <= '0;
        end else begin
            lane_valid <= in_valid;
        end
    end

    // Payload stage
    always_ff @(posedge clk) begin
        rnd_q    <= rnd_d;
        lane_sub <= sub;
        lane_x0  <= x_share0;
        lane_x1  <= x_share1;
        lane_y0  <= y_share0;
        lane_y1  <= y_share1;
    end

    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_rnd_out
        assign lane_rnd[l*WIDTH +: WIDTH]    = rnd_q[l][WIDTH-1:0];
        assign refresh_rnd[l*WIDTH +: WIDTH] = rnd_q[l][RND_BITS-1:WIDTH];
    end

endmodule : mask_rng_feeder

`default_nettype wire

// File: logic/masked_boolean_addsub.sv
/*
 * Pipelined masked ripple adder/subtractor
 * One masked full adder per bit, one bit per cycle. Operand bits
 * are skewed to meet their carry and sums are deskewed so that
 * the whole word leaves together, WIDTH+2 cycles after entry.
 * Subtract inverts share 0 of y and injects a carry-in of 1
 */
`timescale 1ns/100ps
`default_nettype none

module masked_boolean_addsub
    import masked_pkg::*;
#(
    parameter int WIDTH = DEF_WIDTH
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            zeroize,
    input  logic                            sub_i,
    input  logic [WIDTH-1:0][N_SHARES-1:0]  x,   // Per-bit share pairs
    input  logic [WIDTH-1:0][N_SHARES-1:0]  y,
    input  logic [WIDTH-1:0]                rnd,
    output logic [WIDTH-1:0][N_SHARES-1:0]  s
);

    // Carry into bit i, carry[0] is the subtract carry-in
    logic [WIDTH-1:0][N_SHARES-1:0] carry;
    logic [WIDTH-1:0][N_SHARES-1:0] sum;   // Raw adder sums, skewed
    logic                           sub_q; // Carry-in aligned with bit 0

    // Bit 0 operands reach their adder one cycle after entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sub_q <= 1'b0;
        end else if (zeroize) begin
            sub_q <= 1'b0;
        end else begin
            sub_q <= sub_i;
        end
    end

    assign carry[0] = {1'b0, sub_q};       // Two's complement +1 on share 0

    // ============================================================
    // Per-bit skew, adder and deskew
    // ============================================================
    for (genvar i = 0; i < WIDTH; i++) begin : gen_bit
        logic [i:0][N_SHARES-1:0]       x_dly;     // Operand skew, i+1 deep
        logic [i:0][N_SHARES-1:0]       y_dly;
        logic [WIDTH-1-i:0][N_SHARES-1:0] s_dly;   // Sum deskew

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                x_dly <= '0;
                y_dly <= '0;
            end else if (zeroize) begin
                x_dly <= '0;
                y_dly <= '0;
            end else begin
                x_dly[0] <= x[i];
                y_dly[0] <= y[i] ^ {1'b0, sub_i};  // Invert one share only
                for (int k = 1; k <= i; k++) begin
                    x_dly[k] <= x_dly[k-1];
                    y_dly[k] <= y_dly[k-1];
                end
            end
        end

        if (i < WIDTH-1) begin : gen_fa
            masked_full_adder u_masked_full_adder (
                .clk     (clk),
                .rst_n   (rst_n),
                .zeroize (zeroize),
                .x       (x_dly[i]),       // Bit i arrives at cycle i+1
                .y       (y_dly[i]),
                .c_in    (carry[i]),
                .rnd     (rnd[i]),
                .s       (sum[i]),
                .c_out   (carry[i+1])
            );
        end else begin : gen_top
            // Top bit has no carry out, sum only, refreshed by the spare bit
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    sum[i] <= '0;
                end else if (zeroize) begin
                    sum[i] <= '0;
                end else begin
                    sum[i] <= x_dly[i] ^ y_dly[i] ^ carry[i] ^ {rnd[i], rnd[i]};
                end
            end
        end

        // Bit i sum is ready at cycle i+2, pad to WIDTH+2
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                s_dly <= '0;
            end else if (zeroize) begin
                s_dly <= '0;
            end else begin
                s_dly[0] <= sum[i];
                for (int k = 1; k <= WIDTH-1-i; k++) begin
                    s_dly[k] <= s_dly[k-1];
                end
            end
        end

        assign s[i] = s_dly[WIDTH-1-i];
    end

endmodule : masked_boolean_addsub

`default_nettype wire

// File: logic/masked_full_adder.sv
/*
 * Two-share masked full adder
 * Sum is the share-wise XOR of operands and carry. Carry uses
 * the majority form ((x^c)&(y^c))^c with one DOM AND gate.
 * Both outputs registered, one cycle through
 */
`timescale 1ns/100ps
`default_nettype none

module masked_full_adder
    import masked_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                zeroize,
    input  logic [N_SHARES-1:0] x,
    input  logic [N_SHARES-1:0] y,
    input  logic [N_SHARES-1:0] c_in,
    input  logic                rnd,       // Fresh bit for the cross terms
    output logic [N_SHARES-1:0] s,
    output logic [N_SHARES-1:0] c_out
);

    logic [N_SHARES-1:0] a_t;              // x ^ c, share-wise
    logic [N_SHARES-1:0] b_t;              // y ^ c, share-wise
    logic [N_SHARES-1:0] and_t;            // DOM product shares

    assign a_t = x ^ c_in;
    assign b_t = y ^ c_in;

    // Inner-domain products plus cross-domain products,
    // each cross term blinded by the same fresh bit
    assign and_t[0] = (a_t[0] & b_t[0]) ^ ((a_t[0] & b_t[1]) ^ rnd);
    assign and_t[1] = (a_t[1] & b_t[1]) ^ ((a_t[1] & b_t[0]) ^ rnd);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s     <= '0;
            c_out <= '0;
        end else if (zeroize) begin
            s     <= '0;
            c_out <= '0;
        end else begin
            s     <= x ^ y ^ c_in;         // Linear, stays per domain
            c_out <= and_t ^ c_in;         // Majority of x, y, c
        end
    end

endmodule : masked_full_adder

`default_nettype wire

// File: logic/mask_rng_pkg.sv
/*
 * Mask randomness constants
 * Galois register polynomial, fallback seed and the
 * per-lane salt that decorrelates the lane generators
 */
`default_nettype none

package mask_rng_pkg;

    parameter int LFSR_WIDTH = 32;

    // Taps for x^32 + x^22 + x^2 + x + 1, right-shifting form
    parameter logic [LFSR_WIDTH-1:0] LFSR_POLY = 32'h8020_0003;

    // Used when a zero seed is loaded, never all zero
    parameter logic [LFSR_WIDTH-1:0] DEF_SEED = 32'hACE1_2468;

    // Scaled by lane index, XORed into each lane seed
    parameter logic [LFSR_WIDTH-1:0] LANE_SEED_SALT = 32'h9E37_79B9;

endpackage : mask_rng_pkg

`default_nettype wire

// File: logic/masked_pkg.sv
/*
 * Masked arithmetic parameters
 * Share count, default datapath sizes and the fixed
 * latency constants of the masked lane pipeline
 */
`default_nettype none

package masked_pkg;

    // ============================================================
    // Sharing
    // ============================================================
    parameter int N_SHARES = 2;        // First-order Boolean masking

    // ============================================================
    // Default datapath size
    // ============================================================
    parameter int DEF_WIDTH = 8;       // Operand bits per lane
    parameter int DEF_LANES = 4;       // Independent lanes

    // ============================================================
    // Latency
    // ============================================================
    // Ripple adder takes WIDTH cycles plus this many
    parameter int ADDSUB_EXTRA_LAT = 2;
    parameter int COLLECT_LAT      = 1; // Remask output register

endpackage : masked_pkg

`default_nettype wire
